//--- golden_program.txt
# P start pc, M word address and data, A expected strobe address
# T n closes test n, unlisted memory reads as zero
P 20400000
M 20400000 204000B7
M 20400004 10008113
M 20400008 FFC00193
M 2040000C 40310233
M 20400010 00419293
M 20400014 4022D313
M 20400018 01C2D393
M 2040001C 0001A433
M 20400020 0001B4B3
M 20400024 0083C533
M 20400028 006205B3
M 2040002C 00A5E5B3
M 20400030 0065F5B3
M 20400034 0105A603
M 20400038 00360703
M 2040003C 10072003
M 20400040 00164703
M 20400044 00472003
M 20400048 00261703
M 2040004C 00172003
M 20400050 00065703
M 20400054 00072003
M 20400058 00941463
M 20400060 0001C463
M 20400068 0001E463
M 2040006C 00305463
M 20400074 00307463
M 20400078 00048463
M 20400080 00C00A6F
M 2040008C 000A2003
M 20400090 018A0AE7
M 2040009C 004AA003
M 204000A0 00001B17
M 204000A4 000B2003
M 204000A8 0000006F
M 20400100 20400108
M 20400108 80FF7F04
A 20400000
T 1
A 20400004
A 20400008
A 2040000C
A 20400010
A 20400014
A 20400018
A 2040001C
A 20400020
A 20400024
A 20400028
A 2040002C
A 20400030
A 20400034
A 20400100
T 2
A 20400038
A 2040010B
A 2040003C
A 00000080
A 20400040
A 20400109
A 20400044
A 00000083
A 20400048
A 2040010A
A 2040004C
A FFFF8100
A 20400050
A 20400108
A 20400054
A 00007F04
T 3
A 20400058
A 20400060
A 20400068
A 2040006C
A 20400074
A 20400078
A 20400080
T 4
A 2040008C
A 20400084
A 20400090
A 2040009C
A 20400098
A 204000A0
A 204000A4
A 204010A0
T 5
A 204000A8
A 204000A8
T 6

//--- list.f
rv_pkg.sv
rv_bus_if.sv
rv_wb_master.sv
rv_decoder.sv
rv_datapath.sv
rv_sequencer.sv
rv_core_top.sv
rv_core_props.sv
tb_rv_core.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_rv_core -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi

if ! grep -q "Test passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0

//--- rv_bus_if.sv
`timescale 1ns/1ps

interface rv_bus_if;

    logic          req;
    rv_pkg::word_t addr;
    rv_pkg::word_t rdata;
    logic          done;

    modport master (input req, input addr, output rdata, output done);

    modport client (output req, output addr, input done);

    // datapath only looks at returned load data
    modport monitor (input rdata);

endinterface

//--- rv_core_props.sv
`timescale 1ns/1ps

module rv_core_props (
    input logic i_clk,
    input logic i_rst,
    input logic o_cyc,
    input logic o_stb,
    input logic i_ack,
    input logic i_stall
);

    stb_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
        o_stb |=> !o_stb) else $error("o_stb high for more than one cycle");

    // every bus cycle opens with a strobe
    stb_at_open: assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(o_cyc) |-> o_stb) else $error("o_cyc opened without o_stb");

    stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_rst)
        o_stb |-> o_cyc) else $error("o_stb outside o_cyc");

    cyc_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        o_cyc && !(i_ack && !i_stall) |=> o_cyc) else $error("o_cyc dropped before ack");

    idle_after_reset: assert property (@(posedge i_clk)
        i_rst |=> !o_cyc) else $error("o_cyc high after reset");

endmodule

bind rv_core_top rv_core_props props0 (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .o_cyc   (o_cyc),
    .o_stb   (o_stb),
    .i_ack   (i_ack),
    .i_stall (i_stall)
);

//--- rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top #(
    parameter rv_pkg::word_t PC_START = rv_pkg::default_pc_start
) (
    input  logic          i_clk,
    input  logic          i_rst,
    input  logic          i_ack,
    input  logic          i_stall,
    input  rv_pkg::word_t i_data,
    output logic          o_cyc,
    output logic          o_stb,
    output rv_pkg::word_t o_addr
);

    rv_pkg::opcode_e  opcode;
    logic [2:0]       f3;
    logic             f7_alt;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    rv_pkg::word_t    imm;
    rv_pkg::word_t    pc;
    rv_pkg::word_t    next_pc;
    rv_pkg::word_t    load_addr;
    logic             is_load;
    logic             decode_en;
    logic             exec_en;
    logic             load_en;

    rv_bus_if bus ();

    rv_wb_master master0 (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_ack   (i_ack),
        .i_stall (i_stall),
        .i_data  (i_data),
        .o_cyc   (o_cyc),
        .o_stb   (o_stb),
        .o_addr  (o_addr),
        .bus     (bus.master)
    );

    // instruction word comes straight from the captured read data
    rv_decoder decoder0 (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_decode_en (decode_en),
        .i_word      (bus.rdata),
        .o_opcode    (opcode),
        .o_f3        (f3),
        .o_f7_alt    (f7_alt),
        .o_rs1       (rs1),
        .o_rs2       (rs2),
        .o_rd        (rd),
        .o_imm       (imm)
    );

    rv_datapath datapath0 (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_exec_en   (exec_en),
        .i_load_en   (load_en),
        .i_opcode    (opcode),
        .i_f3        (f3),
        .i_f7_alt    (f7_alt),
        .i_rs1       (rs1),
        .i_rs2       (rs2),
        .i_rd        (rd),
        .i_imm       (imm),
        .i_pc        (pc),
        .bus         (bus.monitor),
        .o_next_pc   (next_pc),
        .o_load_addr (load_addr),
        .o_is_load   (is_load)
    );

    rv_sequencer #(
        .PC_START (PC_START)
    ) sequencer0 (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .bus         (bus.client),
        .i_next_pc   (next_pc),
        .i_load_addr (load_addr),
        .i_is_load   (is_load),
        .o_pc        (pc),
        .o_decode_en (decode_en),
        .o_exec_en   (exec_en),
        .o_load_en   (load_en)
    );

endmodule

//--- rv_datapath.sv
`timescale 1ns/1ps

module rv_datapath (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_exec_en,
    input  logic             i_load_en,
    input  rv_pkg::opcode_e  i_opcode,
    input  logic [2:0]       i_f3,
    input  logic             i_f7_alt,
    input  rv_pkg::reg_idx_t i_rs1,
    input  rv_pkg::reg_idx_t i_rs2,
    input  rv_pkg::reg_idx_t i_rd,
    input  rv_pkg::word_t    i_imm,
    input  rv_pkg::word_t    i_pc,
    rv_bus_if.monitor        bus,
    output rv_pkg::word_t    o_next_pc,
    output rv_pkg::word_t    o_load_addr,
    output logic             o_is_load
);

    localparam int xl = rv_pkg::xlen;

    rv_pkg::word_t regs [rv_pkg::reg_count];
    rv_pkg::word_t rs1_val;
    rv_pkg::word_t rs2_val;
    rv_pkg::word_t opb;
    rv_pkg::word_t alu_res;
    rv_pkg::word_t wr_data;
    rv_pkg::word_t pc_plus4;
    rv_pkg::word_t pc_target;
    rv_pkg::word_t lane;
    rv_pkg::word_t load_val;
    logic          eq;
    logic          lt;
    logic          ltu;
    logic          taken;
    logic          exec_wr;

    // x0 reads as zero and is never written
    assign rs1_val = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign rs2_val = (i_rs2 == '0) ? '0 : regs[i_rs2];

    assign opb = (i_opcode == rv_pkg::op_reg || i_opcode == rv_pkg::op_branch) ?
                 rs2_val : i_imm;

    assign eq  = (rs1_val == opb);
    assign lt  = ($signed(rs1_val) < $signed(opb));
    assign ltu = (rs1_val < opb);

    always_comb begin
        case (i_f3)
            rv_pkg::alu_add: begin
                if (i_opcode == rv_pkg::op_reg && i_f7_alt) begin
                    alu_res = rs1_val - opb;
                end else begin
                    alu_res = rs1_val + opb;
                end
            end
            rv_pkg::alu_sll:  alu_res = rs1_val << opb[4:0];
            rv_pkg::alu_slt:  alu_res = {{(xl-1){1'b0}}, lt};
            rv_pkg::alu_sltu: alu_res = {{(xl-1){1'b0}}, ltu};
            rv_pkg::alu_xor:  alu_res = rs1_val ^ opb;
            rv_pkg::alu_srl_sra: begin
                if (i_f7_alt) begin
                    alu_res = $signed(rs1_val) >>> opb[4:0];
                end else begin
                    alu_res = rs1_val >> opb[4:0];
                end
            end
            rv_pkg::alu_or:   alu_res = rs1_val | opb;
            default:          alu_res = rs1_val & opb;
        endcase
    end

    always_comb begin
        case (i_f3)
            rv_pkg::br_beq:  taken = eq;
            rv_pkg::br_bne:  taken = !eq;
            rv_pkg::br_blt:  taken = lt;
            rv_pkg::br_bge:  taken = !lt;
            rv_pkg::br_bltu: taken = ltu;
            rv_pkg::br_bgeu: taken = !ltu;
            default:         taken = 1'b0;
        endcase
    end

    assign pc_plus4    = i_pc + 32'd4;
    assign pc_target   = i_pc + i_imm;
    // shared by loads and jalr
    assign o_load_addr = rs1_val + i_imm;
    assign o_is_load   = (i_opcode == rv_pkg::op_load);

    always_comb begin
        case (i_opcode)
            rv_pkg::op_jal:    o_next_pc = pc_target;
            rv_pkg::op_jalr:   o_next_pc = {o_load_addr[xl-1:1], 1'b0};
            rv_pkg::op_branch: o_next_pc = taken ? pc_target : pc_plus4;
            default:           o_next_pc = pc_plus4;
        endcase
    end

    always_comb begin
        exec_wr = 1'b1;
        case (i_opcode)
            rv_pkg::op_lui:                  wr_data = i_imm;
            rv_pkg::op_auipc:                wr_data = pc_target;
            rv_pkg::op_jal, rv_pkg::op_jalr: wr_data = pc_plus4;
            rv_pkg::op_imm, rv_pkg::op_reg:  wr_data = alu_res;
            default: begin
                wr_data = alu_res;
                exec_wr = 1'b0;
            end
        endcase
    end

    // byte lane from the low address bits
    assign lane = bus.rdata >> {o_load_addr[1:0], 3'b000};

    always_comb begin
        case (i_f3)
            rv_pkg::ld_lb:  load_val = {{(xl-8){lane[7]}}, lane[7:0]};
            rv_pkg::ld_lh:  load_val = {{(xl-16){lane[15]}}, lane[15:0]};
            rv_pkg::ld_lbu: load_val = {{(xl-8){1'b0}}, lane[7:0]};
            rv_pkg::ld_lhu: load_val = {{(xl-16){1'b0}}, lane[15:0]};
            default:        load_val = bus.rdata;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst && i_rd != '0) begin
            if (i_exec_en && exec_wr) begin
                regs[i_rd] <= wr_data;
            end else if (i_load_en) begin
                regs[i_rd] <= load_val;
            end
        end
    end

endmodule

//--- rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              i_decode_en,
    input  rv_pkg::word_t     i_word,
    output rv_pkg::opcode_e   o_opcode,
    output logic [2:0]        o_f3,
    output logic              o_f7_alt,
    output rv_pkg::reg_idx_t  o_rs1,
    output rv_pkg::reg_idx_t  o_rs2,
    output rv_pkg::reg_idx_t  o_rd,
    output rv_pkg::word_t     o_imm
);

    rv_pkg::opcode_e opcode_d;
    rv_pkg::word_t   imm_d;
    rv_pkg::word_t   imm_i;
    rv_pkg::word_t   imm_b;
    rv_pkg::word_t   imm_u;
    rv_pkg::word_t   imm_j;

    assign imm_i = {{20{i_word[31]}}, i_word[31:20]};
    assign imm_b = {{19{i_word[31]}}, i_word[31], i_word[7], i_word[30:25], i_word[11:8], 1'b0};
    assign imm_u = {i_word[31:12], 12'b0};
    assign imm_j = {{11{i_word[31]}}, i_word[31], i_word[19:12], i_word[20],
                    i_word[30:21], 1'b0};

    // immediate format follows the major opcode
    always_comb begin
        opcode_d = rv_pkg::op_nop;
        imm_d    = imm_i;
        case (i_word[6:0])
            rv_pkg::op_lui, rv_pkg::op_auipc: begin
                opcode_d = rv_pkg::opcode_e'(i_word[6:0]);
                imm_d    = imm_u;
            end
            rv_pkg::op_jal: begin
                opcode_d = rv_pkg::op_jal;
                imm_d    = imm_j;
            end
            rv_pkg::op_branch: begin
                opcode_d = rv_pkg::op_branch;
                imm_d    = imm_b;
            end
            rv_pkg::op_jalr, rv_pkg::op_imm, rv_pkg::op_reg, rv_pkg::op_load: begin
                opcode_d = rv_pkg::opcode_e'(i_word[6:0]);
            end
            default: begin
                opcode_d = rv_pkg::op_nop;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_opcode <= rv_pkg::op_nop;
        end else if (i_decode_en) begin
            o_opcode <= opcode_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_decode_en) begin
            o_f3     <= i_word[14:12];
            o_f7_alt <= i_word[rv_pkg::f7_alt];
            o_rs1    <= i_word[19:15];
            o_rs2    <= i_word[24:20];
            o_rd     <= i_word[11:7];
            o_imm    <= imm_d;
        end
    end

endmodule

//--- rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;
    localparam int reg_count = 32;

    typedef logic [4:0] reg_idx_t;
    typedef logic [xlen-1:0] word_t;

    localparam word_t default_pc_start = 32'h2040_0000;

    // bit 30 of the instruction word selects sub and sra
    localparam int f7_alt = 30;

    // op_nop stands in for every opcode the core does not execute
    typedef enum logic [6:0] {
        op_nop    = 7'b0000000,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_load   = 7'b0000011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add     = 3'b000,
        alu_sll     = 3'b001,
        alu_slt     = 3'b010,
        alu_sltu    = 3'b011,
        alu_xor     = 3'b100,
        alu_srl_sra = 3'b101,
        alu_or      = 3'b110,
        alu_and     = 3'b111
    } alu_f3_e;

    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } branch_f3_e;

    typedef enum logic [2:0] {
        ld_lb  = 3'b000,
        ld_lh  = 3'b001,
        ld_lw  = 3'b010,
        ld_lbu = 3'b100,
        ld_lhu = 3'b101
    } load_f3_e;

    typedef enum logic [2:0] {
        stage_fetch,
        stage_wait_fetch,
        stage_decode,
        stage_execute,
        stage_wait_load
    } stage_e;

endpackage

//--- rv_sequencer.sv
`timescale 1ns/1ps

module rv_sequencer #(
    parameter rv_pkg::word_t PC_START
) (
    input  logic          i_clk,
    input  logic          i_rst,
    rv_bus_if.client      bus,
    input  rv_pkg::word_t i_next_pc,
    input  rv_pkg::word_t i_load_addr,
    input  logic          i_is_load,
    output rv_pkg::word_t o_pc,
    output logic          o_decode_en,
    output logic          o_exec_en,
    output logic          o_load_en
);

    rv_pkg::stage_e stage;
    logic           in_load;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            stage <= rv_pkg::stage_fetch;
            o_pc  <= PC_START;
        end else begin
            case (stage)
                rv_pkg::stage_fetch: begin
                    stage <= rv_pkg::stage_wait_fetch;
                end
                rv_pkg::stage_wait_fetch: begin
                    if (bus.done) begin
                        stage <= rv_pkg::stage_decode;
                    end
                end
                rv_pkg::stage_decode: begin
                    stage <= rv_pkg::stage_execute;
                end
                rv_pkg::stage_execute: begin
                    o_pc  <= i_next_pc;
                    stage <= i_is_load ? rv_pkg::stage_wait_load : rv_pkg::stage_fetch;
                end
                rv_pkg::stage_wait_load: begin
                    if (bus.done) begin
                        stage <= rv_pkg::stage_fetch;
                    end
                end
                default: begin
                    stage <= rv_pkg::stage_fetch;
                end
            endcase
        end
    end

    // load address is stable from execute until its data returns
    assign in_load = (stage == rv_pkg::stage_execute && i_is_load) ||
                     (stage == rv_pkg::stage_wait_load);

    assign bus.req  = (stage == rv_pkg::stage_fetch) ||
                      (stage == rv_pkg::stage_execute && i_is_load);
    assign bus.addr = in_load ? i_load_addr : o_pc;

    assign o_decode_en = (stage == rv_pkg::stage_decode);
    assign o_exec_en   = (stage == rv_pkg::stage_execute);
    assign o_load_en   = (stage == rv_pkg::stage_wait_load) && bus.done;

endmodule

//--- rv_wb_master.sv
`timescale 1ns/1ps

module rv_wb_master (
    input  logic          i_clk,
    input  logic          i_rst,
    input  logic          i_ack,
    input  logic          i_stall,
    input  rv_pkg::word_t i_data,
    output logic          o_cyc,
    output logic          o_stb,
    output rv_pkg::word_t o_addr,
    rv_bus_if.master      bus
);

    logic pending;
    logic cyc_open;
    logic start;
    logic close;

    // start only on a quiet bus with no cycle in flight
    assign start = pending && !i_stall && !cyc_open;
    // ack counts only while stall is low
    assign close = cyc_open && i_ack && !i_stall;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pending  <= 1'b0;
            cyc_open <= 1'b0;
            o_stb    <= 1'b0;
            o_addr   <= '0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= close;
            o_stb    <= 1'b0;
            if (bus.req) begin
                pending <= 1'b1;
            end
            if (start) begin
                pending  <= 1'b0;
                cyc_open <= 1'b1;
                o_stb    <= 1'b1;
                o_addr   <= bus.addr;
            end
            if (close) begin
                cyc_open <= 1'b0;
                o_addr   <= '0;
            end
        end
    end

    // read data stays put until the next access ends
    always_ff @(posedge i_clk) begin
        if (close) begin
            bus.rdata <= i_data;
        end
    end

    assign o_cyc = cyc_open;

endmodule

//--- tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam int timeout_cycles = 200;

    logic          i_clk;
    logic          i_rst;
    logic          i_ack;
    logic          i_stall;
    rv_pkg::word_t i_data;
    logic          o_cyc;
    logic          o_stb;
    rv_pkg::word_t o_addr;

    rv_pkg::word_t mem [rv_pkg::word_t];
    rv_pkg::word_t trace [$];
    int            test_end [$];
    int            test_num [$];
    rv_pkg::word_t start_pc;
    logic [31:0]   lfsr;
    int            errors;
    int            checks;

    // slave model state
    logic          busy;
    int            lat;
    int            stall_cnt;
    rv_pkg::word_t ack_addr;

    rv_core_top dut0 (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_ack   (i_ack),
        .i_stall (i_stall),
        .i_data  (i_data),
        .o_cyc   (o_cyc),
        .o_stb   (o_stb),
        .o_addr  (o_addr)
    );

    initial begin
        i_clk = 1'b0;
    end

    always #20 i_clk = ~i_clk;

    // taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic int random_bits(int n);
        int v;
        int k;
        v = 0;
        for (k = 0; k < n; k++) begin
            v = (v << 1) | int'(lfsr_bit());
        end
        return v;
    endfunction

    function automatic rv_pkg::word_t read_word(rv_pkg::word_t a);
        rv_pkg::word_t aligned;
        aligned = {a[31:2], 2'b00};
        return mem.exists(aligned) ? mem[aligned] : '0;
    endfunction

    task automatic load_golden();
        int              fd;
        int              r;
        logic [7:0]      ch;
        rv_pkg::word_t   a;
        rv_pkg::word_t   d;
        int              n;
        logic [8*160-1:0] skip;
        fd = $fopen("golden_program.txt", "r");
        if (fd == 0) begin
            $display("could not open golden_program.txt");
            errors++;
        end else begin
            while ($fscanf(fd, " %c", ch) == 1) begin
                case (ch)
                    "M": begin
                        r = $fscanf(fd, "%h %h", a, d);
                        mem[a] = d;
                    end
                    "A": begin
                        r = $fscanf(fd, "%h", a);
                        trace.push_back(a);
                    end
                    "T": begin
                        r = $fscanf(fd, "%d", n);
                        test_num.push_back(n);
                        test_end.push_back(trace.size());
                    end
                    "P": begin
                        r = $fscanf(fd, "%h", start_pc);
                    end
                    default: begin
                        r = $fgets(skip, fd);
                    end
                endcase
            end
            $fclose(fd);
        end
    endtask

    // waits for the next strobe edge by edge
    task automatic wait_strobe(output logic ok);
        int cnt;
        cnt = 0;
        @(posedge i_clk);
        while (!o_stb && cnt < timeout_cycles) begin
            @(posedge i_clk);
            cnt++;
        end
        ok = o_stb;
    endtask

    // memory slave with random ack latency and short stall bursts
    always @(posedge i_clk) begin
        if (i_rst) begin
            busy      = 1'b0;
            lat       = 0;
            stall_cnt = 0;
            ack_addr  = '0;
        end else begin
            if (busy && i_ack && !i_stall) begin
                busy = 1'b0;
            end
            if (o_stb) begin
                busy     = 1'b1;
                lat      = random_bits(2);
                ack_addr = o_addr;
            end else if (busy && lat > 0) begin
                lat--;
            end
            if (stall_cnt > 0) begin
                stall_cnt--;
            end else if (random_bits(3) == 0) begin
                stall_cnt = 1 + random_bits(1);
            end
        end
        #2;
        i_stall = (stall_cnt > 0);
        i_ack   = busy && (lat == 0);
        i_data  = (busy && lat == 0) ? read_word(ack_addr) : '0;
    end

    initial begin
        int   idx;
        int   t;
        int   n;
        int   errs_before;
        logic ok;
        logic timed_out;
        lfsr      = 32'd90837;
        errors    = 0;
        checks    = 0;
        start_pc  = '0;
        timed_out = 1'b0;
        i_rst     = 1'b1;
        i_ack     = 1'b0;
        i_stall   = 1'b0;
        i_data    = '0;
        load_golden();
        repeat (10) @(posedge i_clk);
        #2 i_rst = 1'b0;
        @(posedge i_clk);
        checks++;
        assert (!o_cyc) else begin
            $display("ERROR %0t o_cyc expected 0 got %b", $time, o_cyc);
            errors++;
        end
        checks++;
        assert (!o_stb) else begin
            $display("ERROR %0t o_stb expected 0 got %b", $time, o_stb);
            errors++;
        end
        idx = 0;
        for (t = 0; t < test_end.size() && !timed_out; t++) begin
            errs_before = errors;
            n = 0;
            while (idx < test_end[t] && !timed_out) begin
                wait_strobe(ok);
                if (!ok) begin
                    $display("no bus strobe within limit");
                    errors++;
                    timed_out = 1'b1;
                end else begin
                    checks++;
                    assert (o_addr == trace[idx]) else begin
                        $display("ERROR %0t o_addr expected %h got %h",
                                 $time, trace[idx], o_addr);
                        errors++;
                    end
                    if (idx == 0) begin
                        checks++;
                        assert (o_addr == start_pc) else begin
                            $display("ERROR %0t o_addr expected %h got %h",
                                     $time, start_pc, o_addr);
                            errors++;
                        end
                    end
                    idx++;
                    n++;
                end
            end
            $display("test %0d: %0d strobes, %0d errors", test_num[t], n,
                     errors - errs_before);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
